//--- core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int xlen = 64;

    // operations handed to the memory stage
    typedef enum logic [2:0] {
        op_none,
        op_load,
        op_csrrw,
        op_csrrs,
        op_ecall,
        op_mret
    } op_e;

    // load kinds, all cut from the aligned 64-bit word
    typedef enum logic [2:0] {
        ld,
        lw,
        lwu,
        lh,
        lbu
    } load_e;

    // machine csr addresses
    localparam logic [11:0] csr_mstatus = 12'd768;
    localparam logic [11:0] csr_mie     = 12'd772;
    localparam logic [11:0] csr_mtvec   = 12'd773;
    localparam logic [11:0] csr_mepc    = 12'd833;
    localparam logic [11:0] csr_mcause  = 12'd834;

    localparam int mstatus_mie  = 3;
    localparam int mstatus_mpie = 7;
    localparam int mie_mtie     = 7;

    localparam logic [xlen-1:0] cause_ecall = 64'd11;
    // interrupt bit on top, machine timer code 7
    localparam logic [xlen-1:0] cause_timer = {1'b1, 63'd7};

endpackage

`default_nettype wire

//--- bus_pkg.sv
`default_nettype none

package bus_pkg;

    localparam int addr_w = 64;
    localparam int id_w   = 4;

    // requester ids echoed back with each read
    localparam logic [id_w-1:0] id_fetch = 4'd1;
    localparam logic [id_w-1:0] id_mem   = 4'd2;

    // clint registers, answered without the bus
    localparam logic [addr_w-1:0] clint_mtimecmp_addr = 64'h0000_0000_0200_4000;
    localparam logic [addr_w-1:0] clint_mtime_addr    = 64'h0000_0000_0200_bff8;

endpackage

`default_nettype wire

//--- csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire core_pkg::op_e               op,
    input  wire logic [11:0]                 csr_addr,
    input  wire logic [core_pkg::xlen-1:0]   src1,
    input  wire logic [core_pkg::xlen-1:0]   src2,
    input  wire logic [core_pkg::xlen-1:0]   pc,
    input  wire logic                        timer_irq,
    output logic      [core_pkg::xlen-1:0]   mepc,
    output logic      [core_pkg::xlen-1:0]   mcause,
    output logic      [core_pkg::xlen-1:0]   mtvec,
    output logic      [core_pkg::xlen-1:0]   mstatus,
    output logic      [core_pkg::xlen-1:0]   mie
);
    import core_pkg::*;

    logic take_irq;
    logic trap;

    // csrrs also folds src2 into the set mask
    function automatic logic [xlen-1:0] csr_next(input logic [xlen-1:0] old);
        if (op == op_csrrs) begin
            return old | src1 | src2;
        end
        return src1;
    endfunction

    // timer only taken between instructions with interrupts globally on
    assign take_irq = timer_irq && (op == op_none) && mstatus[mstatus_mie];
    assign trap     = take_irq || (op == op_ecall);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc    <= '0;
            mcause  <= '0;
            mtvec   <= '0;
            mstatus <= '0;
            mie     <= '0;
        end else if (trap) begin
            mepc                  <= pc;
            mcause                <= take_irq ? cause_timer : cause_ecall;
            mstatus[mstatus_mpie] <= mstatus[mstatus_mie];
            mstatus[mstatus_mie]  <= 1'b0;
        end else if (op == op_mret) begin
            mstatus[mstatus_mie]  <= mstatus[mstatus_mpie];
            mstatus[mstatus_mpie] <= 1'b1;
        end else if (op == op_csrrw || op == op_csrrs) begin
            case (csr_addr)
                csr_mstatus: mstatus <= csr_next(mstatus);
                csr_mie:     mie     <= csr_next(mie);
                csr_mtvec:   mtvec   <= csr_next(mtvec);
                csr_mepc:    mepc    <= csr_next(mepc);
                csr_mcause:  mcause  <= csr_next(mcause);
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- mem_clint.sv
`timescale 1ns/1ps
`default_nettype none

module mem_clint (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        mmio_valid,
    input  wire logic [bus_pkg::addr_w-1:0]  mmio_addr,
    input  wire logic [core_pkg::xlen-1:0]   mtimecmp,
    input  wire logic [core_pkg::xlen-1:0]   mstatus,
    input  wire logic [core_pkg::xlen-1:0]   mie,
    output logic      [core_pkg::xlen-1:0]   read_data,
    output logic                             timer_irq
);
    import core_pkg::*;
    import bus_pkg::*;

    logic [xlen-1:0] mtime;
    logic            irq_en_q;

    // free running timer, one tick per clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime    <= '0;
            irq_en_q <= 1'b0;
        end else begin
            mtime    <= mtime + 1'b1;
            irq_en_q <= mstatus[mstatus_mie] & mie[mie_mtie];
        end
    end

    // mmio read, zero for anything not decoded
    always_comb begin
        read_data = '0;
        if (mmio_valid) begin
            if (mmio_addr == clint_mtime_addr) begin
                read_data = mtime;
            end else if (mmio_addr == clint_mtimecmp_addr) begin
                read_data = mtimecmp;
            end
        end
    end

    // level while the compare holds, enable lags one cycle
    assign timer_irq = irq_en_q && (mtime >= mtimecmp);

endmodule

`default_nettype wire

//--- mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire core_pkg::op_e               op,
    input  wire core_pkg::load_e             load_kind,
    input  wire logic [core_pkg::xlen-1:0]   src1,
    input  wire logic [core_pkg::xlen-1:0]   src2,
    input  wire logic [core_pkg::xlen-1:0]   pc,
    input  wire logic [11:0]                 csr_addr,
    input  wire logic [core_pkg::xlen-1:0]   mtimecmp,
    output logic                             req,
    output logic      [bus_pkg::addr_w-1:0]  addr,
    input  wire logic                        gnt,
    input  wire logic [core_pkg::xlen-1:0]   rdata,
    input  wire logic                        r_done,
    input  wire logic [bus_pkg::id_w-1:0]    r_id,
    output logic                             res_valid,
    output logic      [core_pkg::xlen-1:0]   load_data,
    output logic                             timer_irq,
    output logic      [core_pkg::xlen-1:0]   mepc,
    output logic      [core_pkg::xlen-1:0]   mcause,
    output logic      [core_pkg::xlen-1:0]   mtvec,
    output logic      [core_pkg::xlen-1:0]   mstatus,
    output logic      [core_pkg::xlen-1:0]   mie
);
    import core_pkg::*;
    import bus_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_req,
        st_wait,
        st_mmio,
        st_done
    } state_e;

    state_e          state_q;
    state_e          state_d;
    logic [xlen-1:0] eff_addr;
    logic            is_clint;
    logic            bus_done;
    logic            mmio_valid;
    logic [xlen-1:0] clint_data;
    logic [xlen-1:0] data_q;
    load_e           kind_q;

    assign eff_addr = src1 + src2;
    assign is_clint = (eff_addr == clint_mtime_addr) || (eff_addr == clint_mtimecmp_addr);
    // only our own id ends the wait, fetch replies pass by
    assign bus_done = r_done && (r_id == id_mem);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (op == op_load) begin
                    state_d = is_clint ? st_mmio : st_req;
                end
            end
            st_req: begin
                if (gnt) begin
                    state_d = st_wait;
                end
            end
            st_wait: begin
                if (bus_done) begin
                    state_d = st_done;
                end
            end
            // clint answers in the same cycle
            st_mmio: state_d = st_done;
            st_done: state_d = st_idle;
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // address and kind taken when the load starts
    always_ff @(posedge clk) begin
        if (state_q == st_idle) begin
            addr   <= eff_addr;
            kind_q <= load_kind;
        end
        if (state_q == st_mmio) begin
            data_q <= clint_data;
        end else if (state_q == st_wait && bus_done) begin
            data_q <= rdata;
        end
    end

    // request held through the wait, until our reply
    assign req        = (state_q == st_req) || (state_q == st_wait);
    assign mmio_valid = (state_q == st_mmio);
    assign res_valid  = (state_q == st_done);

    // sub-word loads use the low bytes of the word
    always_comb begin
        case (kind_q)
            ld:      load_data = data_q;
            lw:      load_data = {{32{data_q[31]}}, data_q[31:0]};
            lwu:     load_data = {32'd0, data_q[31:0]};
            lh:      load_data = {{48{data_q[15]}}, data_q[15:0]};
            lbu:     load_data = {56'd0, data_q[7:0]};
            default: load_data = data_q;
        endcase
    end

    csr_file csr_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op),
        .csr_addr  (csr_addr),
        .src1      (src1),
        .src2      (src2),
        .pc        (pc),
        .timer_irq (timer_irq),
        .mepc      (mepc),
        .mcause    (mcause),
        .mtvec     (mtvec),
        .mstatus   (mstatus),
        .mie       (mie)
    );

    mem_clint mem_clint_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .mmio_valid (mmio_valid),
        .mmio_addr  (addr),
        .mtimecmp   (mtimecmp),
        .mstatus    (mstatus),
        .mie        (mie),
        .read_data  (clint_data),
        .timer_irq  (timer_irq)
    );

endmodule

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter logic [bus_pkg::addr_w-1:0] fetch_base = 'h100
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        fetch_en,
    output logic                             req,
    output logic      [bus_pkg::addr_w-1:0]  addr,
    input  wire logic                        gnt,
    input  wire logic [core_pkg::xlen-1:0]   rdata,
    input  wire logic                        r_done,
    input  wire logic [bus_pkg::id_w-1:0]    r_id,
    output logic                             instr_valid,
    output logic      [core_pkg::xlen-1:0]   instr
);
    import bus_pkg::*;

    logic granted_q;

    // a reply counts only once our request has been granted
    assign instr_valid = granted_q && r_done && (r_id == id_fetch);
    assign instr       = rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr      <= fetch_base;
            req       <= 1'b0;
            granted_q <= 1'b0;
        end else if (instr_valid) begin
            // drop req for a cycle so the other side gets a turn
            addr      <= addr + 8;
            req       <= 1'b0;
            granted_q <= 1'b0;
        end else begin
            if (!req && fetch_en) begin
                req <= 1'b1;
            end
            if (req && gnt) begin
                granted_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        fetch_req,
    input  wire logic [bus_pkg::addr_w-1:0]  fetch_addr,
    input  wire logic                        mem_req,
    input  wire logic [bus_pkg::addr_w-1:0]  mem_addr,
    output logic                             fetch_gnt,
    output logic                             mem_gnt,
    output logic                             ram_valid,
    output logic      [bus_pkg::addr_w-1:0]  ram_addr,
    output logic      [bus_pkg::id_w-1:0]    ram_id,
    input  wire logic                        r_done
);
    import bus_pkg::*;

    logic busy_q;
    logic owner_mem_q;
    logic last_mem_q;
    logic pick_mem;
    logic sel_mem;

    // round robin, the side served last loses a tie
    assign pick_mem = (fetch_req && mem_req) ? !last_mem_q : mem_req;
    assign sel_mem  = busy_q ? owner_mem_q : pick_mem;

    assign fetch_gnt = busy_q ? !owner_mem_q : (fetch_req && !pick_mem);
    assign mem_gnt   = busy_q ? owner_mem_q : (mem_req && pick_mem);
    assign ram_valid = (fetch_gnt && fetch_req) || (mem_gnt && mem_req);
    assign ram_addr  = sel_mem ? mem_addr : fetch_addr;
    assign ram_id    = sel_mem ? id_mem : id_fetch;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q      <= 1'b0;
            owner_mem_q <= 1'b0;
            // fetch wins the first tie
            last_mem_q  <= 1'b1;
        end else if (!busy_q) begin
            if (fetch_req || mem_req) begin
                busy_q      <= 1'b1;
                owner_mem_q <= pick_mem;
                last_mem_q  <= pick_mem;
            end
        end else if (r_done) begin
            busy_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int read_latency = 3,
    parameter int ram_words    = 256
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        ram_valid,
    input  wire logic [bus_pkg::addr_w-1:0]  ram_addr,
    input  wire logic [bus_pkg::id_w-1:0]    ram_id,
    output logic      [core_pkg::xlen-1:0]   rdata,
    output logic                             r_done,
    output logic      [bus_pkg::id_w-1:0]    r_id
);
    import core_pkg::*;

    localparam int idx_w = $clog2(ram_words);
    localparam int cnt_w = $clog2(read_latency + 1);

    logic [xlen-1:0]  mem [ram_words];
    logic [idx_w-1:0] idx_q;
    logic [cnt_w-1:0] cnt_q;
    logic             busy_q;

    // fixed contents, a recognizable pattern per word
    initial begin
        for (int i = 0; i < ram_words; i++) begin
            mem[i] = {32'h1234_0000 + 32'(i), 32'hffff_8000 + 32'(i)};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (!busy_q) begin
            if (ram_valid) begin
                busy_q <= 1'b1;
                cnt_q  <= cnt_w'(read_latency - 1);
            end
        end else if (cnt_q == '0) begin
            busy_q <= 1'b0;
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // word index wraps on the memory size
    always_ff @(posedge clk) begin
        if (!busy_q && ram_valid) begin
            idx_q <= ram_addr[3 +: idx_w];
            r_id  <= ram_id;
        end
    end

    assign r_done = busy_q && (cnt_q == '0);
    assign rdata  = mem[idx_q];

endmodule

`default_nettype wire

//--- mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
    parameter int                         read_latency = 3,
    parameter int                         ram_words    = 256,
    parameter logic [bus_pkg::addr_w-1:0] fetch_base   = 'h100
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire core_pkg::op_e               op,
    input  wire core_pkg::load_e             load_kind,
    input  wire logic [core_pkg::xlen-1:0]   src1,
    input  wire logic [core_pkg::xlen-1:0]   src2,
    input  wire logic [core_pkg::xlen-1:0]   pc,
    input  wire logic [11:0]                 csr_addr,
    input  wire logic [core_pkg::xlen-1:0]   mtimecmp,
    input  wire logic                        fetch_en,
    output logic                             res_valid,
    output logic      [core_pkg::xlen-1:0]   load_data,
    output logic                             timer_irq,
    output logic      [core_pkg::xlen-1:0]   mepc,
    output logic      [core_pkg::xlen-1:0]   mcause,
    output logic      [core_pkg::xlen-1:0]   mtvec,
    output logic      [core_pkg::xlen-1:0]   mstatus,
    output logic      [core_pkg::xlen-1:0]   mie,
    output logic                             instr_valid,
    output logic      [core_pkg::xlen-1:0]   instr
);
    import core_pkg::*;
    import bus_pkg::*;

    logic              fetch_req;
    logic [addr_w-1:0] fetch_addr;
    logic              fetch_gnt;
    logic              mem_req;
    logic [addr_w-1:0] mem_addr;
    logic              mem_gnt;
    logic              ram_valid;
    logic [addr_w-1:0] ram_addr;
    logic [id_w-1:0]   ram_id;
    // read reply, seen by both requesters
    logic [xlen-1:0]   rdata;
    logic              r_done;
    logic [id_w-1:0]   r_id;

    fetch_unit #(
        .fetch_base (fetch_base)
    ) fetch_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_en    (fetch_en),
        .req         (fetch_req),
        .addr        (fetch_addr),
        .gnt         (fetch_gnt),
        .rdata       (rdata),
        .r_done      (r_done),
        .r_id        (r_id),
        .instr_valid (instr_valid),
        .instr       (instr)
    );

    mem_stage mem_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op),
        .load_kind (load_kind),
        .src1      (src1),
        .src2      (src2),
        .pc        (pc),
        .csr_addr  (csr_addr),
        .mtimecmp  (mtimecmp),
        .req       (mem_req),
        .addr      (mem_addr),
        .gnt       (mem_gnt),
        .rdata     (rdata),
        .r_done    (r_done),
        .r_id      (r_id),
        .res_valid (res_valid),
        .load_data (load_data),
        .timer_irq (timer_irq),
        .mepc      (mepc),
        .mcause    (mcause),
        .mtvec     (mtvec),
        .mstatus   (mstatus),
        .mie       (mie)
    );

    bus_arbiter bus_arbiter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .fetch_gnt  (fetch_gnt),
        .mem_gnt    (mem_gnt),
        .ram_valid  (ram_valid),
        .ram_addr   (ram_addr),
        .ram_id     (ram_id),
        .r_done     (r_done)
    );

    data_ram #(
        .read_latency (read_latency),
        .ram_words    (ram_words)
    ) data_ram_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ram_valid (ram_valid),
        .ram_addr  (ram_addr),
        .ram_id    (ram_id),
        .rdata     (rdata),
        .r_done    (r_done),
        .r_id      (r_id)
    );

endmodule

`default_nettype wire

//--- tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;
    import core_pkg::*;
    import bus_pkg::*;

    localparam int          read_latency = 3;
    localparam int          ram_words    = 256;
    localparam logic [63:0] fetch_base   = 64'h100;
    localparam int          max_wait     = 200;
    // far beyond any mtime this run reaches
    localparam logic [63:0] cmp_far      = 64'h7fff_0000_dead_beef;
    localparam logic [63:0] timer_pc     = 64'h8000_0240;

    // which DUT output a table row is compared against
    typedef enum logic [2:0] {
        out_load,
        out_mepc,
        out_mcause,
        out_mtvec,
        out_mstatus,
        out_mie
    } out_e;

    logic        clk = 1'b0;
    logic        rst_n;
    op_e         op;
    load_e       load_kind;
    logic [63:0] src1;
    logic [63:0] src2;
    logic [63:0] pc;
    logic [11:0] csr_addr;
    logic [63:0] mtimecmp;
    logic        fetch_en;
    logic        res_valid;
    logic [63:0] load_data;
    logic        timer_irq;
    logic [63:0] mepc;
    logic [63:0] mcause;
    logic [63:0] mtvec;
    logic [63:0] mstatus;
    logic [63:0] mie;
    logic        instr_valid;
    logic [63:0] instr;

    // stimulus table with one entry per row in each queue
    string       row_name[$];
    op_e         row_op[$];
    load_e       row_kind[$];
    logic [63:0] row_src1[$];
    logic [63:0] row_src2[$];
    logic [11:0] row_csr[$];
    logic [63:0] row_pc[$];
    logic [63:0] row_exp[$];
    out_e        row_out[$];

    logic [31:0] lcg_state = 32'h8965c456;
    int          fetch_count = 0;

    mem_subsys_top #(
        .read_latency (read_latency),
        .ram_words    (ram_words),
        .fetch_base   (fetch_base)
    ) mem_subsys_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .op          (op),
        .load_kind   (load_kind),
        .src1        (src1),
        .src2        (src2),
        .pc          (pc),
        .csr_addr    (csr_addr),
        .mtimecmp    (mtimecmp),
        .fetch_en    (fetch_en),
        .res_valid   (res_valid),
        .load_data   (load_data),
        .timer_irq   (timer_irq),
        .mepc        (mepc),
        .mcause      (mcause),
        .mtvec       (mtvec),
        .mstatus     (mstatus),
        .mie         (mie),
        .instr_valid (instr_valid),
        .instr       (instr)
    );

    always begin
        #20 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected ram contents for a word index
    function automatic logic [63:0] preload_word(input logic [31:0] idx);
        return {32'h1234_0000 + idx, 32'hffff_8000 + idx};
    endfunction

    function automatic logic [63:0] extend_load(input load_e kind, input logic [63:0] w);
        case (kind)
            lw:      return 64'($signed(w[31:0]));
            lwu:     return {32'd0, w[31:0]};
            lh:      return 64'($signed(w[15:0]));
            lbu:     return {56'd0, w[7:0]};
            default: return w;
        endcase
    endfunction

    function automatic load_e kind_of(input int n);
        case (n % 5)
            1:       return lw;
            2:       return lwu;
            3:       return lh;
            4:       return lbu;
            default: return ld;
        endcase
    endfunction

    function automatic logic [63:0] pick_output(input out_e which);
        case (which)
            out_mepc:    return mepc;
            out_mcause:  return mcause;
            out_mtvec:   return mtvec;
            out_mstatus: return mstatus;
            out_mie:     return mie;
            default:     return load_data;
        endcase
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("Fail %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic add_row(input string name, input op_e r_op, input load_e kind,
                           input logic [63:0] a, input logic [63:0] b, input logic [11:0] csr,
                           input logic [63:0] r_pc, input logic [63:0] expected,
                           input out_e which);
        row_name.push_back(name);
        row_op.push_back(r_op);
        row_kind.push_back(kind);
        row_src1.push_back(a);
        row_src2.push_back(b);
        row_csr.push_back(csr);
        row_pc.push_back(r_pc);
        row_exp.push_back(expected);
        row_out.push_back(which);
    endtask

    // csrrw then csrrs on one register
    task automatic add_csr_pair(input string name, input logic [11:0] csr, input out_e which);
        logic [63:0] v;
        logic [63:0] b;
        logic [63:0] c;
        v = {next_random(), next_random()};
        b = {next_random(), next_random()};
        c = {32'd0, next_random()};
        add_row({"csrrw_", name}, op_csrrw, ld, v, 64'd0, csr, 64'd0, v, which);
        add_row({"csrrs_", name}, op_csrrs, ld, b, c, csr, 64'd0, v | b | c, which);
    endtask

    task automatic build_table();
        logic [31:0] idx;
        logic [63:0] word_addr;
        logic [63:0] split;
        load_e       kind;
        for (int i = 0; i < 15; i++) begin
            idx       = next_random() % 32'(ram_words);
            word_addr = {29'd0, idx, 3'd0};
            split     = {32'd0, next_random()};
            kind      = kind_of(i);
            add_row($sformatf("load_%0d_%s_word_%0d", i, kind.name(), idx), op_load, kind,
                    split, word_addr - split, 12'd0, 64'd0,
                    extend_load(kind, preload_word(idx)), out_load);
        end
        add_csr_pair("mstatus", csr_mstatus, out_mstatus);
        add_csr_pair("mie", csr_mie, out_mie);
        add_csr_pair("mtvec", csr_mtvec, out_mtvec);
        add_csr_pair("mepc", csr_mepc, out_mepc);
        add_csr_pair("mcause", csr_mcause, out_mcause);
        // ecall with MIE set and then mret
        add_row("mstatus_set_mie", op_csrrw, ld, 64'h8, 64'd0, csr_mstatus, 64'd0, 64'h8,
                out_mstatus);
        add_row("ecall_mepc", op_ecall, ld, 64'd0, 64'd0, 12'd0, 64'h8000_0100,
                64'h8000_0100, out_mepc);
        add_row("ecall_mcause", op_none, ld, 64'd0, 64'd0, 12'd0, 64'd0, 64'd11, out_mcause);
        add_row("ecall_mstatus", op_none, ld, 64'd0, 64'd0, 12'd0, 64'd0, 64'h80, out_mstatus);
        add_row("mret_mstatus", op_mret, ld, 64'd0, 64'd0, 12'd0, 64'd0, 64'h88, out_mstatus);
        add_row("mmio_mtimecmp", op_load, ld, clint_mtimecmp_addr - 64'h40, 64'h40, 12'd0,
                64'd0, cmp_far, out_load);
    endtask

    // called and returns on a falling edge
    task automatic apply_row(input string name, input op_e r_op, input load_e kind,
                             input logic [63:0] a, input logic [63:0] b,
                             input logic [11:0] csr, input logic [63:0] r_pc,
                             input logic [63:0] expected, input out_e which);
        int waited;
        op        = r_op;
        load_kind = kind;
        src1      = a;
        src2      = b;
        csr_addr  = csr;
        pc        = r_pc;
        if (r_op == op_load) begin
            waited = 0;
            // the previous load may still hold res_valid in this cycle
            do begin
                @(negedge clk);
                waited++;
                if (waited > max_wait) begin
                    report_failure($sformatf("no load result for %s after %0d cycles",
                                             name, waited));
                end
            end while (!res_valid);
        end else begin
            // csr effects land on the next rising edge
            @(posedge clk);
            @(negedge clk);
        end
        op = op_none;
        check_value(name, expected, pick_output(which));
    endtask

    task automatic wait_timer_irq();
        int waited;
        waited = 0;
        while (!timer_irq) begin
            @(negedge clk);
            waited++;
            if (waited > max_wait) begin
                report_failure("timer interrupt never rose");
            end
        end
    endtask

    // every fetched word must follow the sequential pc
    always @(negedge clk) begin
        if (rst_n && instr_valid) begin
            check_value($sformatf("fetch_%0d", fetch_count),
                        preload_word((32'(fetch_base >> 3) + 32'(fetch_count))
                                     % 32'(ram_words)),
                        instr);
            fetch_count = fetch_count + 1;
        end
    end

    initial begin
        rst_n     = 1'b0;
        op        = op_none;
        load_kind = ld;
        src1      = 64'd0;
        src2      = 64'd0;
        pc        = 64'd0;
        csr_addr  = 12'd0;
        mtimecmp  = cmp_far;
        fetch_en  = 1'b0;
        build_table();

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("reset_res_valid", 64'd0, 64'(res_valid));
        check_value("reset_mstatus", 64'd0, mstatus);
        check_value("reset_mtvec", 64'd0, mtvec);
        fetch_en = 1'b1;

        for (int r = 0; r < row_name.size(); r++) begin
            apply_row(row_name[r], row_op[r], row_kind[r], row_src1[r], row_src2[r],
                      row_csr[r], row_pc[r], row_exp[r], row_out[r]);
        end

        // timer interrupt entry with MTIE and then MIE enabled
        apply_row("timer_mstatus_clear", op_csrrw, ld, 64'd0, 64'd0, csr_mstatus, 64'd0,
                  64'd0, out_mstatus);
        apply_row("timer_mie_mtie", op_csrrw, ld, 64'h80, 64'd0, csr_mie, 64'd0, 64'h80,
                  out_mie);
        mtimecmp = 64'd16;
        apply_row("timer_mstatus_mie", op_csrrs, ld, 64'h8, 64'd0, csr_mstatus, timer_pc,
                  64'h8, out_mstatus);
        wait_timer_irq();
        @(posedge clk);
        @(negedge clk);
        check_value("timer_mcause", {1'b1, 63'd7}, mcause);
        check_value("timer_mepc", timer_pc, mepc);
        check_value("timer_mstatus", 64'h80, mstatus);

        check_value("fetch_progress", 64'd1, 64'(fetch_count >= 4));
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
core_pkg.sv
bus_pkg.sv
csr_file.sv
mem_clint.sv
mem_stage.sv
fetch_unit.sv
bus_arbiter.sv
data_ram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

//--- run.sh
#!/bin/sh
# build with verilator and run, the exit status is the verdict
verilator --binary --timing --timescale 1ns/1ps --top-module tb_mem_subsys \
    -f vlog.f -o tb_mem_subsys \
    && ./obj_dir/tb_mem_subsys \
    || { echo "simulation build or run failed"; exit 1; }
